// ==== eth_phy_tx_gt_ctrl.f ====
+incdir+.
eth_phy_tx_pkg.sv
tx_reset_seq.sv
tx_gbx_seq_gen.sv
tx_gt_port.sv
eth_phy_tx_gt_ctrl.sv
eth_phy_tx_gt_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TX GT control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
TOP=eth_phy_tx_gt_ctrl_tb

rm -rf obj_dir
verilator --binary -j 0 \
    --top-module "${TOP}" \
    -f eth_phy_tx_gt_ctrl.f \
    -o "${TOP}_sim"

./obj_dir/"${TOP}_sim" | tee "${LOG}"

if grep -q "Simulation finished: PASS" "${LOG}"; then
    echo "run_sim: passed"
    exit 0
else
    echo "run_sim: failed, see ${LOG}"
    exit 1
fi

// ==== eth_phy_tx_gt_ctrl_tb.sv ====
// Testbench for the TX GT control with GT reset-done model, gearbox monitor and table checks
`timescale 1ns/1ps
`include "eth_phy_tx_defines.svh"

module eth_phy_tx_gt_ctrl_tb;

    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = 30 * `SEQ_LEN + RESET_CYCLES;
    localparam int NUM_ENTRIES = 12;
    localparam int LOCK_LOW_CYCLES = 5;
    localparam int DONE_TIMEOUT = 20;
    localparam eth_phy_tx_pkg::seq_cnt_t SEQ_LAST = eth_phy_tx_pkg::seq_cnt_t'(`SEQ_LEN - 1);

    // Stimulus table of MAC word, MAC header, gearbox sync flag and expected GT word and header
    localparam eth_phy_tx_pkg::data_word_t TBL_DATA [NUM_ENTRIES] = '{
        32'h1e00_0000, 32'hdead_beef, 32'h0123_4567, 32'h89ab_cdef,
        32'hffff_ffff, 32'h0000_0001, 32'h5555_aaaa, 32'haaaa_5555,
        32'h8000_0000, 32'h7fff_ffff, 32'hc0de_face, 32'h0f0f_f0f0};
    localparam eth_phy_tx_pkg::sync_hdr_t TBL_HDR [NUM_ENTRIES] = '{
        2'b10, 2'b01, 2'b10, 2'b01, 2'b11, 2'b01,
        2'b10, 2'b01, 2'b00, 2'b10, 2'b01, 2'b10};
    localparam logic TBL_SYNC [NUM_ENTRIES] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
        1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam eth_phy_tx_pkg::data_word_t TBL_EXP_DATA [NUM_ENTRIES] = '{
        32'h1e00_0000, 32'hdead_beef, 32'h0123_4567, 32'h89ab_cdef,
        32'hffff_ffff, 32'h0000_0001, 32'h5555_aaaa, 32'haaaa_5555,
        32'h8000_0000, 32'h7fff_ffff, 32'hc0de_face, 32'h0f0f_f0f0};
    localparam eth_phy_tx_pkg::gt_hdr_t TBL_EXP_HDR [NUM_ENTRIES] = '{
        6'h02, 6'h01, 6'h02, 6'h01, 6'h03, 6'h01,
        6'h02, 6'h01, 6'h00, 6'h02, 6'h01, 6'h02};

    logic tx_clk;
    logic reset;
    logic qpll_lock;
    logic gt_tx_reset_done;
    logic gt_tx_reset;
    logic gt_tx_userrdy;
    eth_phy_tx_pkg::data_word_t serdes_tx_data;
    eth_phy_tx_pkg::sync_hdr_t serdes_tx_hdr;
    logic serdes_tx_gbx_sync;
    logic serdes_tx_gbx_req_sync;
    logic serdes_tx_gbx_req_stall;
    eth_phy_tx_pkg::data_word_t gt_txdata;
    eth_phy_tx_pkg::gt_hdr_t gt_txheader;
    eth_phy_tx_pkg::seq_cnt_t gt_txsequence;
    logic tx_rst_out;

    int errors;
    int checks;
    int done_wait;
    logic done_at_edge;

    // Sequence counter model before and after the last edge
    eth_phy_tx_pkg::seq_cnt_t seq_model;
    eth_phy_tx_pkg::seq_cnt_t seq_prev;

    eth_phy_tx_gt_ctrl uut (
        .tx_clk(tx_clk),
        .reset(reset),
        .qpll_lock(qpll_lock),
        .gt_tx_reset_done(gt_tx_reset_done),
        .gt_tx_reset(gt_tx_reset),
        .gt_tx_userrdy(gt_tx_userrdy),
        .serdes_tx_data(serdes_tx_data),
        .serdes_tx_hdr(serdes_tx_hdr),
        .serdes_tx_gbx_sync(serdes_tx_gbx_sync),
        .serdes_tx_gbx_req_sync(serdes_tx_gbx_req_sync),
        .serdes_tx_gbx_req_stall(serdes_tx_gbx_req_stall),
        .gt_txdata(gt_txdata),
        .gt_txheader(gt_txheader),
        .gt_txsequence(gt_txsequence),
        .tx_rst_out(tx_rst_out)
    );

    initial tx_clk = 1'b0;
    always #5 tx_clk = ~tx_clk;

    // GT model raises reset-done a random delay after gt_tx_reset falls
    initial begin
        gt_tx_reset_done = 1'b0;
        done_wait = 0;
        forever begin
            @(posedge tx_clk);
            #1;
            if (gt_tx_reset) begin
                done_wait = 3 + ($urandom % 8);
                gt_tx_reset_done = 1'b0;
            end else if (done_wait > 0) begin
                done_wait = done_wait - 1;
            end else begin
                gt_tx_reset_done = 1'b1;
            end
        end
    end

    // What the DUT saw of reset-done at each edge
    always @(posedge tx_clk) begin
        done_at_edge <= gt_tx_reset_done;
    end

    task automatic check_word(input string name, input eth_phy_tx_pkg::data_word_t got,
                              input eth_phy_tx_pkg::data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_hdr(input string name, input eth_phy_tx_pkg::gt_hdr_t got,
                             input eth_phy_tx_pkg::gt_hdr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_seq(input string name, input eth_phy_tx_pkg::seq_cnt_t got,
                             input eth_phy_tx_pkg::seq_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string what);
        checks++;
        errors++;
        $display("Error: %s at %0t", what, $time);
    endtask

    // One clock; inputs change 1 ns after the edge
    task automatic tick();
        @(posedge tx_clk);
        #1;
        seq_prev = seq_model;
        if (reset) begin
            seq_model = '0;
        end else if (serdes_tx_gbx_sync) begin
            seq_model = eth_phy_tx_pkg::seq_cnt_t'(1);
        end else if (seq_model == SEQ_LAST) begin
            seq_model = '0;
        end else begin
            seq_model = eth_phy_tx_pkg::seq_cnt_t'(seq_model + 1);
        end
    endtask

    task automatic check_idle_outputs();
        check_word("gt_txdata", gt_txdata, '0);
        check_hdr("gt_txheader", gt_txheader, '0);
        check_seq("gt_txsequence", gt_txsequence, '0);
        check_bit("tx_rst_out", tx_rst_out, 1'b1);
    endtask

    task automatic bring_up_link();
        int high_cycles;
        int wait_cycles;
        int rst_cycles;
        logic rdy_seen;

        // Random MAC data makes the output gating visible
        serdes_tx_data = $urandom;
        serdes_tx_hdr = eth_phy_tx_pkg::sync_hdr_t'($urandom);
        repeat (LOCK_LOW_CYCLES) begin
            tick();
            check_bit("gt_tx_reset", gt_tx_reset, 1'b1);
            check_bit("gt_tx_userrdy", gt_tx_userrdy, 1'b0);
            check_idle_outputs();
        end

        qpll_lock = 1'b1;
        high_cycles = 0;
        tick();
        while (gt_tx_reset && high_cycles < 4 * `GT_RESET_CYCLES) begin
            high_cycles++;
            check_bit("gt_tx_userrdy", gt_tx_userrdy, 1'b0);
            check_idle_outputs();
            tick();
        end
        if (high_cycles != `GT_RESET_CYCLES) begin
            report_error($sformatf("gt_tx_reset stayed high %0d cycles after lock instead of %0d",
                                   high_cycles, `GT_RESET_CYCLES));
        end

        // Ready follows the edge that sees reset-done
        wait_cycles = 0;
        rdy_seen = 1'b0;
        while (!rdy_seen && wait_cycles < DONE_TIMEOUT) begin
            check_bit("gt_tx_userrdy", gt_tx_userrdy, done_at_edge);
            check_bit("gt_tx_reset", gt_tx_reset, 1'b0);
            check_idle_outputs();
            rdy_seen = gt_tx_userrdy || done_at_edge;
            if (!rdy_seen) begin
                tick();
                wait_cycles++;
            end
        end
        if (!rdy_seen) begin
            report_error("gt_tx_userrdy never rose after the GT reset was released");
        end

        rst_cycles = 0;
        while (tx_rst_out && rst_cycles < 4 * `RST_SYNC_STAGES) begin
            tick();
            rst_cycles++;
        end
        if (rst_cycles != `RST_SYNC_STAGES) begin
            report_error($sformatf("tx_rst_out fell %0d cycles after ready instead of %0d",
                                   rst_cycles, `RST_SYNC_STAGES));
        end
    endtask

    task automatic apply_table();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            serdes_tx_data = TBL_DATA[i];
            serdes_tx_hdr = TBL_HDR[i];
            serdes_tx_gbx_sync = TBL_SYNC[i];
            tick();
            check_word("gt_txdata", gt_txdata, TBL_EXP_DATA[i]);
            check_hdr("gt_txheader", gt_txheader, TBL_EXP_HDR[i]);
            check_seq("gt_txsequence", gt_txsequence, seq_prev >> 1);
        end
        serdes_tx_gbx_sync = 1'b0;
    endtask

    task automatic drop_lock();
        qpll_lock = 1'b0;
        serdes_tx_data = $urandom;
        tick();
        check_bit("gt_tx_reset", gt_tx_reset, 1'b1);
        check_bit("gt_tx_userrdy", gt_tx_userrdy, 1'b0);
        tick();
        check_idle_outputs();
    endtask

    // Sync request every SEQ_LEN cycles and stall on the last two before it
    initial begin : gbx_monitor
        int since_sync;
        @(negedge reset);
        since_sync = `SEQ_LEN - 1;
        forever begin
            @(posedge tx_clk);
            #1;
            since_sync = since_sync + 1;
            check_bit("serdes_tx_gbx_req_sync", serdes_tx_gbx_req_sync,
                      since_sync == `SEQ_LEN);
            check_bit("serdes_tx_gbx_req_stall", serdes_tx_gbx_req_stall,
                      since_sync == `SEQ_LEN - 2 || since_sync == `SEQ_LEN - 1);
            if (since_sync == `SEQ_LEN) begin
                since_sync = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tx_clk);
        $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        void'($urandom(32'hff6f));
        reset = 1'b1;
        qpll_lock = 1'b0;
        serdes_tx_data = '0;
        serdes_tx_hdr = '0;
        serdes_tx_gbx_sync = 1'b0;
        seq_model = '0;
        seq_prev = '0;

        repeat (RESET_CYCLES) tick();
        reset = 1'b0;

        bring_up_link();
        apply_table();

        // Lock loss and full restart
        drop_lock();
        bring_up_link();
        apply_table();

        repeat (2 * `SEQ_LEN) tick();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== eth_phy_tx_gt_ctrl.sv ====
// Top level of the TX GT control with reset sequencer, gearbox sequencer and GT port
`timescale 1ns/1ps

module eth_phy_tx_gt_ctrl (
    input  logic                       tx_clk,
    input  logic                       reset,

    // PLL and GT reset handshake
    input  logic                       qpll_lock,
    input  logic                       gt_tx_reset_done,
    output logic                       gt_tx_reset,
    output logic                       gt_tx_userrdy,

    // MAC side
    input  eth_phy_tx_pkg::data_word_t serdes_tx_data,
    input  eth_phy_tx_pkg::sync_hdr_t  serdes_tx_hdr,
    input  logic                       serdes_tx_gbx_sync,
    output logic                       serdes_tx_gbx_req_sync,
    output logic                       serdes_tx_gbx_req_stall,

    // GT transmit port
    output eth_phy_tx_pkg::data_word_t gt_txdata,
    output eth_phy_tx_pkg::gt_hdr_t    gt_txheader,
    output eth_phy_tx_pkg::seq_cnt_t   gt_txsequence,

    output logic                       tx_rst_out
);

    logic tx_ready;
    eth_phy_tx_pkg::seq_cnt_t seq_count;

    assign gt_tx_userrdy = tx_ready;

    tx_reset_seq reset_seq_inst (
        .tx_clk(tx_clk),
        .reset(reset),
        .qpll_lock(qpll_lock),
        .gt_tx_reset_done(gt_tx_reset_done),
        .gt_tx_reset(gt_tx_reset),
        .gt_tx_userrdy(tx_ready)
    );

    tx_gbx_seq_gen gbx_seq_inst (
        .tx_clk(tx_clk),
        .reset(reset),
        .serdes_tx_gbx_sync(serdes_tx_gbx_sync),
        .serdes_tx_gbx_req_sync(serdes_tx_gbx_req_sync),
        .serdes_tx_gbx_req_stall(serdes_tx_gbx_req_stall),
        .seq_count(seq_count)
    );

    // Data and header go straight from the MAC to the GT port registers
    tx_gt_port gt_port_inst (
        .tx_clk(tx_clk),
        .reset(reset),
        .tx_ready(tx_ready),
        .serdes_tx_data(serdes_tx_data),
        .serdes_tx_hdr(serdes_tx_hdr),
        .seq_count(seq_count),
        .gt_txdata(gt_txdata),
        .gt_txheader(gt_txheader),
        .gt_txsequence(gt_txsequence),
        .tx_rst_out(tx_rst_out)
    );

endmodule

// ==== tx_gt_port.sv ====
// Registered GT transmit outputs with ready gating and tx_rst_out release chain
`timescale 1ns/1ps
`include "eth_phy_tx_defines.svh"

module tx_gt_port (
    input  logic                       tx_clk,
    input  logic                       reset,
    input  logic                       tx_ready,
    input  eth_phy_tx_pkg::data_word_t serdes_tx_data,
    input  eth_phy_tx_pkg::sync_hdr_t  serdes_tx_hdr,
    input  eth_phy_tx_pkg::seq_cnt_t   seq_count,
    output eth_phy_tx_pkg::data_word_t gt_txdata,
    output eth_phy_tx_pkg::gt_hdr_t    gt_txheader,
    output eth_phy_tx_pkg::seq_cnt_t   gt_txsequence,
    output logic                       tx_rst_out
);

    eth_phy_tx_pkg::gt_hdr_t hdr_ext;
    eth_phy_tx_pkg::seq_cnt_t seq_half;
    logic [`RST_SYNC_STAGES-1:0] rst_sync;

    // Sync header sits in the low bits of the GT header
    assign hdr_ext = {{(`GT_HDR_W - `HDR_W){1'b0}}, serdes_tx_hdr};

    // GT counts 64-bit blocks of two 32-bit words each
    assign seq_half = {1'b0, seq_count[`SEQ_W-1:1]};

    always_ff @(posedge tx_clk) begin
        if (tx_ready) begin
            gt_txdata <= serdes_tx_data;
            gt_txheader <= hdr_ext;
            gt_txsequence <= seq_half;
        end else begin
            gt_txdata <= '0;
            gt_txheader <= '0;
            gt_txsequence <= '0;
        end
    end

    // Asserts at once on not-ready and releases after the full chain
    always_ff @(posedge tx_clk) begin
        if (reset || !tx_ready) begin
            rst_sync <= '1;
        end else begin
            rst_sync <= {rst_sync[`RST_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign tx_rst_out = rst_sync[`RST_SYNC_STAGES-1];

endmodule

// ==== tx_gbx_seq_gen.sv ====
// Gearbox sync/stall request generator and realignable TX sequence counter
`timescale 1ns/1ps
`include "eth_phy_tx_defines.svh"

module tx_gbx_seq_gen (
    input  logic                     tx_clk,
    input  logic                     reset,
    input  logic                     serdes_tx_gbx_sync,
    output logic                     serdes_tx_gbx_req_sync,
    output logic                     serdes_tx_gbx_req_stall,
    output eth_phy_tx_pkg::seq_cnt_t seq_count
);

    localparam eth_phy_tx_pkg::seq_cnt_t SEQ_LAST = eth_phy_tx_pkg::seq_cnt_t'(`SEQ_LEN - 1);
    localparam eth_phy_tx_pkg::seq_cnt_t STALL_FIRST = eth_phy_tx_pkg::seq_cnt_t'(2);
    localparam eth_phy_tx_pkg::seq_cnt_t STALL_LAST = eth_phy_tx_pkg::seq_cnt_t'(1);

    eth_phy_tx_pkg::seq_cnt_t gen_cnt;

    // Stalls land on cycles 64 and 65 of each 66 cycle frame
    always_ff @(posedge tx_clk) begin
        if (reset) begin
            gen_cnt <= '0;
            serdes_tx_gbx_req_sync <= 1'b0;
            serdes_tx_gbx_req_stall <= 1'b0;
        end else begin
            serdes_tx_gbx_req_sync <= 1'b0;
            serdes_tx_gbx_req_stall <= 1'b0;

            if (gen_cnt == '0) begin
                gen_cnt <= SEQ_LAST;
                serdes_tx_gbx_req_sync <= 1'b1;
            end else begin
                gen_cnt <= gen_cnt - 1'b1;
            end

            if (gen_cnt == STALL_FIRST || gen_cnt == STALL_LAST) begin
                serdes_tx_gbx_req_stall <= 1'b1;
            end
        end
    end

    // TX sequence realigned by the MAC
    always_ff @(posedge tx_clk) begin
        if (reset) begin
            seq_count <= '0;
        end else if (serdes_tx_gbx_sync) begin
            seq_count <= eth_phy_tx_pkg::seq_cnt_t'(1);
        end else if (seq_count == SEQ_LAST) begin
            seq_count <= '0;
        end else begin
            seq_count <= seq_count + 1'b1;
        end
    end

endmodule

// ==== tx_reset_seq.sv ====
// Transmit reset sequencer with PLL lock wait, timed GT TX reset, reset-done wait and user-ready
`timescale 1ns/1ps
`include "eth_phy_tx_defines.svh"

module tx_reset_seq (
    input  logic tx_clk,
    input  logic reset,
    input  logic qpll_lock,
    input  logic gt_tx_reset_done,
    output logic gt_tx_reset,
    output logic gt_tx_userrdy
);

    localparam int CNT_W = $clog2(`GT_RESET_CYCLES);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`GT_RESET_CYCLES - 1);

    eth_phy_tx_pkg::reset_state_t state;
    eth_phy_tx_pkg::reset_state_t state_next;
    logic [CNT_W-1:0] hold_cnt;

    always_comb begin
        state_next = state;
        case (state)
            eth_phy_tx_pkg::WAIT_LOCK: begin
                if (qpll_lock) begin
                    state_next = eth_phy_tx_pkg::GT_RESET;
                end
            end
            eth_phy_tx_pkg::GT_RESET: begin
                if (hold_cnt == '0) begin
                    state_next = eth_phy_tx_pkg::WAIT_DONE;
                end
            end
            eth_phy_tx_pkg::WAIT_DONE: begin
                if (gt_tx_reset_done) begin
                    state_next = eth_phy_tx_pkg::READY;
                end
            end
            eth_phy_tx_pkg::READY: begin
                state_next = eth_phy_tx_pkg::READY;
            end
            default: begin
                state_next = eth_phy_tx_pkg::WAIT_LOCK;
            end
        endcase

        // Losing lock restarts the whole sequence
        if (!qpll_lock) begin
            state_next = eth_phy_tx_pkg::WAIT_LOCK;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (reset) begin
            state <= eth_phy_tx_pkg::WAIT_LOCK;
            hold_cnt <= HOLD_LAST;
        end else begin
            state <= state_next;

            // Reloaded outside GT_RESET so the hold always lasts the full count
            if (state != eth_phy_tx_pkg::GT_RESET) begin
                hold_cnt <= HOLD_LAST;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // GT reset held until the hold timer expires
    assign gt_tx_reset = (state == eth_phy_tx_pkg::WAIT_LOCK) ||
                         (state == eth_phy_tx_pkg::GT_RESET);
    assign gt_tx_userrdy = (state == eth_phy_tx_pkg::READY);

endmodule

// ==== eth_phy_tx_pkg.sv ====
// Vector types and reset sequencer state encoding for the TX GT control
`include "eth_phy_tx_defines.svh"

package eth_phy_tx_pkg;

    // MAC data word and sync header
    typedef logic [`DATA_W-1:0] data_word_t;
    typedef logic [`HDR_W-1:0] sync_hdr_t;

    // Header as presented to the GT
    typedef logic [`GT_HDR_W-1:0] gt_hdr_t;

    // Gearbox pacing and TX sequence counts
    typedef logic [`SEQ_W-1:0] seq_cnt_t;

    // TX reset sequencer states
    typedef enum logic [1:0] {
        WAIT_LOCK,
        GT_RESET,
        WAIT_DONE,
        READY
    } reset_state_t;

endpackage

// ==== eth_phy_tx_defines.svh ====
// Widths, gearbox sequence length and reset timing for the TX GT control
`ifndef ETH_PHY_TX_DEFINES_SVH
`define ETH_PHY_TX_DEFINES_SVH

// MAC side data word
`define DATA_W 32

// 64b/66b sync header as driven by the MAC
`define HDR_W 2

// Header port width at the GT
`define GT_HDR_W 6

// Gearbox and sequence counters
`define SEQ_W 7
`define SEQ_LEN 66

// GT TX reset hold after PLL lock
`define GT_RESET_CYCLES 16

// Depth of the tx_rst_out release chain
`define RST_SYNC_STAGES 4

`endif
